/* source/cache_sync_config.svh */
`ifndef CACHE_SYNC_CONFIG_SVH
`define CACHE_SYNC_CONFIG_SVH

// geometry shared by the data and instruction caches
// both stores must agree slot for slot, so one set of numbers

// ways per cache
`define CS_WAYS   4

// block slots in each way
`define CS_BLKS   16

// line info word, valid bit on top of the tag
`define CS_INFO_W 26

// line payload, one full cache line
`define CS_LINE_W 512

// slot count is CS_WAYS * CS_BLKS
// keep both powers of two, the walker counts way and block as one index

`endif

/* source/cache_sync_pkg.sv */
`default_nettype none

`include "cache_sync_config.svh"

package cache_sync_pkg;

  // slot address, same layout in both stores
  typedef struct packed {
    logic [$clog2(`CS_WAYS)-1:0] way_id; // upper bits of the walk index
    logic [$clog2(`CS_BLKS)-1:0] blk_id;
  } line_addr_t;

  // per-line bookkeeping word
  typedef struct packed {
    logic                  valid; // zero after reset
    logic [`CS_INFO_W-2:0] tag;
  } line_info_t;

  // raw line payload
  typedef logic [`CS_LINE_W-1:0] line_data_t;

  // one line in flight from dcache to icache
  // used on the read-packet link and on the write link
  typedef struct packed {
    line_addr_t addr; // target slot
    line_info_t info;
    line_data_t data;
  } sync_packet_t;

endpackage

`default_nettype wire

/* source/dcache_line_store.sv */
`default_nettype none

`include "cache_sync_config.svh"

module dcache_line_store
  import cache_sync_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  // host store port
  input  wire               i_store_valid,
  input  wire sync_packet_t i_store_packet,
  output logic              o_store_ready,
  // sync read link
  input  wire               i_sync_rreq,
  output logic              o_sync_rack,
  output logic              o_sync_rpackreq,
  input  wire               i_sync_rpackack,
  output sync_packet_t      o_sync_rpacket
);

  localparam int unsigned SLOTS = `CS_WAYS * `CS_BLKS;
  localparam int unsigned AW    = $bits(line_addr_t);

  // walker states
  localparam logic [1:0] W_IDLE = 2'd0; // host owns the arrays
  localparam logic [1:0] W_SEND = 2'd1; // packet offered, waiting for ack
  localparam logic [1:0] W_GAP  = 2'd2; // rpackreq low for one cycle
  localparam logic [1:0] W_DONE = 2'd3; // rack pulse

  line_info_t info_mem [SLOTS];
  line_data_t data_mem [SLOTS];

  logic [1:0]    walk_state;
  logic [AW-1:0] walk_idx;   // way and block as one counter
  line_addr_t    walk_addr;
  logic          store_en;
  logic          last_slot;

  assign o_store_ready = (walk_state == W_IDLE); // host locked out for the whole walk
  assign store_en      = i_store_valid & o_store_ready;
  assign walk_addr     = walk_idx;                 // way id lands in the upper bits
  assign last_slot     = (walk_idx == AW'(SLOTS - 1));

  // info array, cleared so every line starts invalid
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SLOTS; i++) begin
        info_mem[i] <= '0;
      end
    end else if (store_en) begin
      info_mem[i_store_packet.addr] <= i_store_packet.info;
    end
  end

  always_ff @(posedge clk) begin
    if (store_en) begin
      data_mem[i_store_packet.addr] <= i_store_packet.data;
    end
  end

  // line walker, one packet per slot in address order
  always_ff @(posedge clk) begin
    if (rst) begin
      walk_state      <= W_IDLE;
      walk_idx        <= '0;
      o_sync_rpackreq <= 1'b0;
      o_sync_rack     <= 1'b0;
    end else begin
      case (walk_state)
        W_IDLE: begin
          if (i_sync_rreq) begin
            walk_idx        <= '0; // way 0 block 0 first
            o_sync_rpackreq <= 1'b1;
            walk_state      <= W_SEND;
          end
        end
        W_SEND: begin
          if (i_sync_rpackack) begin
            o_sync_rpackreq <= 1'b0; // engine waits for this drop
            walk_state      <= W_GAP;
          end
        end
        W_GAP: begin
          if (last_slot) begin
            o_sync_rack <= 1'b1;
            walk_state  <= W_DONE;
          end else begin
            walk_idx        <= walk_idx + 1'b1; // new addr and req on the same edge
            o_sync_rpackreq <= 1'b1;
            walk_state      <= W_SEND;
          end
        end
        W_DONE: begin
          o_sync_rack <= 1'b0; // one cycle only
          walk_state  <= W_IDLE;
        end
        default: walk_state <= W_IDLE;
      endcase
    end
  end

  // packet read straight from the arrays, stable while ready is low
  always_comb begin
    o_sync_rpacket.addr = walk_addr;
    o_sync_rpacket.info = info_mem[walk_addr];
    o_sync_rpacket.data = data_mem[walk_addr];
  end

endmodule

`default_nettype wire

/* source/cache_sync.sv */
`default_nettype none

module cache_sync
  import cache_sync_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  // fence.i request from the core
  input  wire               i_fencei_req,
  output logic              o_fencei_ack,
  // dcache read side
  output logic              o_sync_rreq,
  input  wire               i_sync_rack,
  input  wire               i_sync_rpackreq,
  output logic              o_sync_rpackack,
  input  wire sync_packet_t i_sync_rpacket,
  // icache write side
  output logic              o_sync_wreq,
  input  wire               i_sync_wack,
  output sync_packet_t      o_sync_wpacket
);

  localparam logic [1:0] S_IDLE  = 2'd0; // waiting for fence.i
  localparam logic [1:0] S_READ  = 2'd1; // take a packet or finish the walk
  localparam logic [1:0] S_WRITE = 2'd2; // push packet into icache
  localparam logic [1:0] S_ACK   = 2'd3; // ack the packet, wait for rpackreq to fall

  logic [1:0] state;
  logic       hs_rd;        // walk finished
  logic       hs_wr;        // icache took the line
  logic       fence_served; // request already answered
  logic       start;

  assign hs_rd = o_sync_rreq & i_sync_rack;
  assign hs_wr = o_sync_wreq & i_sync_wack;

  // a held request is answered once, needs to drop before the next fence
  assign start = i_fencei_req & ~o_fencei_ack & ~fence_served;

  always_ff @(posedge clk) begin
    if (rst) begin
      fence_served <= 1'b0;
    end else if (!i_fencei_req) begin
      fence_served <= 1'b0;
    end else if (hs_rd) begin
      fence_served <= 1'b1; // rises with the ack
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= S_IDLE;
      o_fencei_ack    <= 1'b0;
      o_sync_rreq     <= 1'b0;
      o_sync_rpackack <= 1'b0;
      o_sync_wreq     <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          o_fencei_ack <= 1'b0; // single-cycle pulse
          if (start) begin
            state <= S_READ;
          end
        end
        S_READ: begin
          if (hs_rd) begin
            o_sync_rreq  <= 1'b0;
            o_fencei_ack <= 1'b1;
            state        <= S_IDLE;
          end else begin
            o_sync_rreq <= 1'b1; // held across write and ack states
            if (i_sync_rpackreq) begin
              state <= S_WRITE; // packet latched this edge
            end
          end
        end
        S_WRITE: begin
          if (hs_wr) begin
            o_sync_wreq     <= 1'b0;
            o_sync_rpackack <= 1'b1;
            state           <= S_ACK;
          end else begin
            o_sync_wreq <= 1'b1;
          end
        end
        S_ACK: begin
          o_sync_rpackack <= 1'b0;
          if (!i_sync_rpackreq) begin
            state <= S_READ; // walker moved on
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // write register, loaded once per offered packet
  always_ff @(posedge clk) begin
    if (state == S_READ && i_sync_rpackreq) begin
      o_sync_wpacket <= i_sync_rpacket;
    end
  end

endmodule

`default_nettype wire

/* source/icache_line_store.sv */
`default_nettype none

`include "cache_sync_config.svh"

module icache_line_store
  import cache_sync_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  // sync write port
  input  wire               i_sync_wreq,
  output logic              o_sync_wack,
  input  wire sync_packet_t i_sync_wpacket,
  // fetch read port
  input  wire line_addr_t   i_fetch_addr,
  output line_info_t        o_fetch_info,
  output line_data_t        o_fetch_data
);

  localparam int unsigned SLOTS = `CS_WAYS * `CS_BLKS;

  line_info_t info_mem [SLOTS];
  line_data_t data_mem [SLOTS];

  logic wr_done; // this request already written
  logic wr_en;

  // one write per request, even if wreq is held past wack
  assign wr_en = i_sync_wreq & ~wr_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_sync_wack <= 1'b0;
      wr_done     <= 1'b0;
    end else begin
      o_sync_wack <= wr_en; // cycle after wreq is seen
      if (wr_en) begin
        wr_done <= 1'b1;
      end else if (!i_sync_wreq) begin
        wr_done <= 1'b0; // rearm once the engine lets go
      end
    end
  end

  // info array, invalid after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < SLOTS; i++) begin
        info_mem[i] <= '0;
      end
    end else if (wr_en) begin
      info_mem[i_sync_wpacket.addr] <= i_sync_wpacket.info;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[i_sync_wpacket.addr] <= i_sync_wpacket.data;
    end
  end

  // fetch side, async read
  assign o_fetch_info = info_mem[i_fetch_addr];
  assign o_fetch_data = data_mem[i_fetch_addr];

endmodule

`default_nettype wire

/* source/cache_sync_top.sv */
`default_nettype none

module cache_sync_top
  import cache_sync_pkg::*;
(
  input  wire               clk,
  input  wire               rst,
  // fence.i
  input  wire               i_fencei_req,
  output logic              o_fencei_ack,
  // host stores into the dcache
  input  wire               i_store_valid,
  input  wire sync_packet_t i_store_packet,
  output logic              o_store_ready,
  // instruction fetch
  input  wire line_addr_t   i_fetch_addr,
  output line_info_t        o_fetch_info,
  output line_data_t        o_fetch_data
);

  // dcache to engine
  logic         sync_rreq;
  logic         sync_rack;
  logic         sync_rpackreq;
  logic         sync_rpackack;
  sync_packet_t sync_rpacket;
  // engine to icache
  logic         sync_wreq;
  logic         sync_wack;
  sync_packet_t sync_wpacket;

  dcache_line_store u_dcache (
    .clk             (clk),
    .rst             (rst),
    .i_store_valid   (i_store_valid),
    .i_store_packet  (i_store_packet),
    .o_store_ready   (o_store_ready),
    .i_sync_rreq     (sync_rreq),
    .o_sync_rack     (sync_rack),
    .o_sync_rpackreq (sync_rpackreq),
    .i_sync_rpackack (sync_rpackack),
    .o_sync_rpacket  (sync_rpacket)
  );

  cache_sync u_sync (
    .clk             (clk),
    .rst             (rst),
    .i_fencei_req    (i_fencei_req),
    .o_fencei_ack    (o_fencei_ack),
    .o_sync_rreq     (sync_rreq),
    .i_sync_rack     (sync_rack),
    .i_sync_rpackreq (sync_rpackreq),
    .o_sync_rpackack (sync_rpackack),
    .i_sync_rpacket  (sync_rpacket),
    .o_sync_wreq     (sync_wreq),
    .i_sync_wack     (sync_wack),
    .o_sync_wpacket  (sync_wpacket)
  );

  icache_line_store u_icache (
    .clk            (clk),
    .rst            (rst),
    .i_sync_wreq    (sync_wreq),
    .o_sync_wack    (sync_wack),
    .i_sync_wpacket (sync_wpacket),
    .i_fetch_addr   (i_fetch_addr),
    .o_fetch_info   (o_fetch_info),
    .o_fetch_data   (o_fetch_data)
  );

endmodule

`default_nettype wire

/* sim/cache_sync_properties.sv */
`default_nettype none

module cache_sync_properties
  import cache_sync_pkg::*;
(
  input wire               clk,
  input wire               rst,
  input wire               o_fencei_ack,
  input wire               i_sync_rpackreq,
  input wire               o_sync_rpackack,
  input wire               o_sync_wreq,
  input wire               i_sync_wack,
  input wire sync_packet_t o_sync_wpacket
);

  timeunit 1ns;
  timeprecision 100ps;

  // packet ack only while the walker offers a packet
  a_rpackack_in_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(o_sync_rpackack) |-> i_sync_rpackreq
  ) else $error("rpackack rose without rpackreq");

  // write request held, packet frozen, until the icache answers
  a_wreq_hold: assert property (
    @(posedge clk) disable iff (rst)
    (o_sync_wreq && !i_sync_wack) |=> (o_sync_wreq && $stable(o_sync_wpacket))
  ) else $error("wreq dropped or wpacket changed before wack");

  a_fence_ack_pulse: assert property (
    @(posedge clk) disable iff (rst)
    o_fencei_ack |=> !o_fencei_ack
  ) else $error("fence.i ack longer than one cycle"); // single pulse per fence

endmodule

bind cache_sync cache_sync_properties u_props (
  .clk             (clk),
  .rst             (rst),
  .o_fencei_ack    (o_fencei_ack),
  .i_sync_rpackreq (i_sync_rpackreq),
  .o_sync_rpackack (o_sync_rpackack),
  .o_sync_wreq     (o_sync_wreq),
  .i_sync_wack     (i_sync_wack),
  .o_sync_wpacket  (o_sync_wpacket)
);

`default_nettype wire

/* sim/tb_cache_sync.sv */
`default_nettype none

`include "cache_sync_config.svh"

module tb_cache_sync
  import cache_sync_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SLOTS       = `CS_WAYS * `CS_BLKS;
  localparam int WAY_W       = $clog2(`CS_WAYS);
  localparam int BLK_W       = $clog2(`CS_BLKS);
  localparam int TAG_W       = `CS_INFO_W - 1;
  localparam int CLK_PER     = 40;
  localparam int SEED        = 62;
  localparam int FENCE_LIMIT = SLOTS * 10;    // generous bound for one walk
  localparam int N_FENCES    = 4;
  localparam int N_SCANS     = 8;             // full sweeps of the fetch port
  localparam int N_STORES    = SLOTS + 16;
  localparam int WATCHDOG_CYCLES = N_FENCES * FENCE_LIMIT + N_SCANS * SLOTS
                                   + N_STORES * 4 + 400;

  logic         clk;
  logic         rst;
  logic         fencei_req;
  logic         fencei_ack;
  logic         store_valid;
  sync_packet_t store_packet;
  logic         store_ready;
  line_addr_t   fetch_addr;
  line_info_t   fetch_info;
  line_data_t   fetch_data;

  line_info_t dc_info [SLOTS]; // what the host wrote into the dcache
  line_data_t dc_data [SLOTS];
  line_info_t ic_info [SLOTS]; // icache view expected at the fetch port
  line_data_t ic_data [SLOTS];
  int         errors;

  cache_sync_top i_cache_sync_top (
    .clk            (clk),
    .rst            (rst),
    .i_fencei_req   (fencei_req),
    .o_fencei_ack   (fencei_ack),
    .i_store_valid  (store_valid),
    .i_store_packet (store_packet),
    .o_store_ready  (store_ready),
    .i_fetch_addr   (fetch_addr),
    .o_fetch_info   (fetch_info),
    .o_fetch_data   (fetch_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PER / 2) clk = ~clk;
  end

  // hang guard sized from the fence and sweep counts
  initial begin
    #(WATCHDOG_CYCLES * CLK_PER);
    $display("simulation hung, watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

  task automatic tick();
    @(posedge clk);
    #2; // drive point with outputs settled
  endtask

  task automatic fail_now(input string msg);
    errors++;
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_info(input string name, input line_info_t got, input line_info_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_data(input string name, input line_data_t got, input line_data_t exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // slot index to way and block with way in the upper bits
  function automatic line_addr_t slot_addr(input int slot);
    line_addr_t a;
    a.way_id = WAY_W'(slot / `CS_BLKS);
    a.blk_id = BLK_W'(slot % `CS_BLKS);
    return a;
  endfunction

  function automatic line_info_t rand_info();
    line_info_t info;
    info.valid = ($urandom % 4) != 0; // roughly one in four invalid
    info.tag   = TAG_W'($urandom);
    return info;
  endfunction

  function automatic line_data_t rand_data();
    line_data_t d;
    for (int k = 0; k < `CS_LINE_W / 32; k++) begin
      d[k*32 +: 32] = $urandom;
    end
    return d;
  endfunction

  // after fence.i every icache slot equals the dcache slot
  task automatic sync_model();
    for (int s = 0; s < SLOTS; s++) begin
      ic_info[s] = dc_info[s];
      ic_data[s] = dc_data[s];
    end
  endtask

  task automatic store_line(input int slot, input line_info_t info, input line_data_t data);
    int waited;
    waited = 0;
    store_valid       = 1'b1;
    store_packet.addr = slot_addr(slot);
    store_packet.info = info;
    store_packet.data = data;
    while (!store_ready) begin
      tick();
      waited++;
      if (waited > FENCE_LIMIT) fail_now("data cache never accepted a host store");
    end
    tick(); // written on this edge
    store_valid   = 1'b0;
    dc_info[slot] = info;
    dc_data[slot] = data;
  endtask

  // raises fence.i and returns the cycle after the ack with the request still up
  task automatic await_fence_ack();
    int waited;
    waited = 0;
    fencei_req = 1'b1;
    do begin
      tick();
      waited++;
      if (waited > FENCE_LIMIT) fail_now("fence.i request was never acknowledged");
    end while (!fencei_ack);
    tick();
    compare_bit("o_fencei_ack", fencei_ack, 1'b0); // one cycle only
    compare_bit("o_store_ready", store_ready, 1'b1);
  endtask

  task automatic run_fence();
    await_fence_ack();
    fencei_req = 1'b0; // dropped the cycle after the ack
    sync_model();
  endtask

  task automatic check_fetch(input bit with_data);
    for (int s = 0; s < SLOTS; s++) begin
      fetch_addr = slot_addr(s);
      #1;
      compare_info($sformatf("o_fetch_info[%0d]", s), fetch_info, ic_info[s]);
      if (with_data) begin
        compare_data($sformatf("o_fetch_data[%0d]", s), fetch_data, ic_data[s]);
      end
      tick();
    end
  endtask

  task automatic test_reset_state();
    compare_bit("o_store_ready", store_ready, 1'b1);
    compare_bit("o_fencei_ack", fencei_ack, 1'b0);
    check_fetch(1'b0); // data undefined until first fence
  endtask

  task automatic test_fill_and_fence();
    line_info_t info;
    for (int s = 0; s < SLOTS; s++) begin
      info = rand_info();
      if (s % 7 == 3) info.valid = 1'b0; // invalid lines get copied too
      store_line(s, info, rand_data());
    end
    run_fence();
    check_fetch(1'b1);
  endtask

  task automatic test_overwrite();
    repeat (10) begin
      store_line($urandom % SLOTS, rand_info(), rand_data());
    end
    check_fetch(1'b1); // icache still stale
    run_fence();
    check_fetch(1'b1);
  endtask

  task automatic test_store_during_fence();
    int         slot;
    int         waited;
    bit         ack_seen;
    line_info_t info;
    line_data_t data;
    slot       = $urandom % SLOTS;
    info       = rand_info();
    info.valid = 1'b1;
    data       = rand_data();
    waited     = 0;
    ack_seen   = 1'b0;
    fencei_req = 1'b1;
    while (store_ready) begin
      tick();
      waited++;
      if (waited > FENCE_LIMIT) fail_now("line walk never started after fence.i");
    end
    store_valid       = 1'b1; // held across the walk
    store_packet.addr = slot_addr(slot);
    store_packet.info = info;
    store_packet.data = data;
    sync_model(); // this fence copies the dcache as it was
    while (!store_ready) begin
      tick();
      waited++;
      if (waited > FENCE_LIMIT) fail_now("held store was never accepted");
      if (fencei_ack) ack_seen = 1'b1;
    end
    if (!ack_seen) fail_now("store port reopened before the fence.i ack");
    tick();
    store_valid   = 1'b0;
    fencei_req    = 1'b0;
    dc_info[slot] = info;
    dc_data[slot] = data;
    check_fetch(1'b1); // new line waits for the next fence
  endtask

  task automatic test_held_request();
    int         slot;
    line_info_t info;
    line_data_t data;
    slot       = $urandom % SLOTS;
    info       = rand_info();
    info.valid = 1'b1;
    data       = rand_data();
    await_fence_ack(); // also carries the store from the last test
    sync_model();
    store_line(slot, info, data); // lands while the request is still high
    fencei_req = 1'b0;
    repeat (20) begin
      compare_bit("o_store_ready", store_ready, 1'b1);
      compare_bit("o_fencei_ack", fencei_ack, 1'b0);
      tick();
    end
    check_fetch(1'b1); // no second sync so the new line stays out of the icache
  endtask

  initial begin
    void'($urandom(SEED));
    errors       = 0;
    rst          = 1'b1;
    fencei_req   = 1'b0;
    store_valid  = 1'b0;
    store_packet = '0;
    fetch_addr   = '0;
    for (int s = 0; s < SLOTS; s++) begin
      dc_info[s] = '0;
      dc_data[s] = '0;
      ic_info[s] = '0;
      ic_data[s] = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    test_reset_state();
    test_fill_and_fence();
    test_overwrite();
    test_store_during_fence();
    test_held_request();
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/cache_sync_pkg.sv
source/dcache_line_store.sv
source/cache_sync.sv
source/icache_line_store.sv
source/cache_sync_top.sv
sim/cache_sync_properties.sv
sim/tb_cache_sync.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module tb_cache_sync -o sim_cache_sync

out=$(./obj_dir/sim_cache_sync 2>&1) || true
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
